/* compile.f */
+incdir+verilog
verilog/snappy_parser_pkg.sv
verilog/leading_zero_count.sv
verilog/slice_tokenizer.sv
verilog/token_lane.sv
verilog/parser_status.sv
verilog/snappy_parser.sv
test/snappy_parser_properties.sv
test/snappy_parser_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the token splitter testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** FAILED ***'

verilator --binary --timing --assert -f compile.f --top-module snappy_parser_tb \
	-Mdir obj_dir -o snappy_parser_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/snappy_parser_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation finished without failure"
exit 0

/* test/snappy_parser_properties.sv */
// Concurrent checks on one lane queue, bound into every token_lane instance.
// Violations are flagged only through the assertions themselves.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module snappy_parser_properties (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           wr_en,
	input logic [$clog2(`LANE_DEPTH):0]   count_q,
	input logic                           rd_i,
	input logic                           valid_o,
	input snappy_parser_pkg::token_kind_e kind_o,
	input logic [`ADDR_W-1:0]             addr_o,
	input logic [`LEN_W-1:0]              len_o,
	input logic [`OFF_W-1:0]              off_o
);

	// the stall must stop traffic before the queue overflows
	no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		(count_q == `LANE_DEPTH) |-> !wr_en)
		else $error("lane accepted a descriptor while full");

	head_held_until_read: assert property (@(posedge clk) disable iff (!rst_n)
		(valid_o && !rd_i) |=> (valid_o && $stable(kind_o) && $stable(addr_o)
			&& $stable(len_o) && $stable(off_o)))
		else $error("lane head changed before it was read");

	valid_low_after_reset: assert property (@(posedge clk) !rst_n |=> !valid_o)
		else $error("lane valid high after reset");

endmodule

bind token_lane snappy_parser_properties u_lane_props (
	.clk     (clk),
	.rst_n   (rst_n),
	.wr_en   (wr_en),
	.count_q (count_q),
	.rd_i    (rd_i),
	.valid_o (valid_o),
	.kind_o  (kind_o),
	.addr_o  (addr_o),
	.len_o   (len_o),
	.off_o   (off_o)
);

/* test/snappy_parser_tb.sv */
// Testbench for the Snappy token splitter. Random slices from a fixed seed
// go through a reference model that sorts descriptors into per-lane queues,
// and a random consumer checks every lane head as it reads it.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module snappy_parser_tb;

	import snappy_parser_pkg::*;

	localparam int WAIT_LIMIT = 4000;	// cycles

	typedef struct packed {
		token_kind_e        kind;
		logic [`ADDR_W-1:0] addr;
		logic [`LEN_W-1:0]  len;
		logic [`OFF_W-1:0]  off;
	} desc_t;

	logic                               clk = 1'b0;
	logic                               rst_n;
	logic                               slice_valid_i;
	logic [`DATA_W-1:0]                 slice_data_i;
	logic [`POS_W-1:0]                  slice_pos_i;
	logic [`ADDR_W-1:0]                 slice_addr_i;
	logic                               ready_o;
	logic [`NUM_LANES-1:0]              lane_rd_i;
	logic [`NUM_LANES-1:0]              lane_valid_o;
	token_kind_e [`NUM_LANES-1:0]       lane_kind_o;
	logic [`NUM_LANES-1:0][`ADDR_W-1:0] lane_addr_o;
	logic [`NUM_LANES-1:0][`LEN_W-1:0]  lane_len_o;
	logic [`NUM_LANES-1:0][`OFF_W-1:0]  lane_off_o;
	logic                               all_empty_o;

	desc_t              exp_q [`NUM_LANES][$];	// model output per lane
	logic [`ADDR_W-1:0] next_addr;			// output address of the next slice
	logic               read_en = 1'b0;
	int                 delivered;

	snappy_parser dut0 (.*);

	always #50 clk = ~clk;

	task automatic report_error(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "wrong value");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	endtask

	task automatic check_kind(input token_kind_e got, input token_kind_e exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
		end
	endtask

	task automatic check_value(input logic [`ADDR_W-1:0] got, input logic [`ADDR_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	function automatic int pending_count();
		int n;
		n = 0;
		for (int l = 0; l < `NUM_LANES; l++) begin
			n += exp_q[l].size();
		end
		return n;
	endfunction

	// compare one lane head with the oldest model entry of that lane
	task automatic take_head(input int lane, input desc_t got);
		desc_t exp;
		string where;
		where = $sformatf("lane %0d", lane);
		if (exp_q[lane].size() == 0) begin
			report_error($sformatf("%s shows addr %h that was never expected", where, got.addr));
		end else begin
			exp = exp_q[lane].pop_front();
			check_value(`ADDR_W'((got.addr >> `LANE_SEL_LSB) % `NUM_LANES), `ADDR_W'(lane),
				{where, " bank of addr"});
			check_kind(got.kind, exp.kind, {where, " kind"});
			check_value(got.addr, exp.addr, {where, " addr"});
			check_value(`ADDR_W'(got.len), `ADDR_W'(exp.len), {where, " len"});
			check_value(got.off, exp.off, {where, " off"});
			delivered++;
		end
	endtask

	// build a random slice, decode it into the model queues, strobe it in
	task automatic drive_slice();
		logic [7:0]         bytes [`SLICE_BYTES + 2];
		logic [`POS_W-1:0]  pos;
		logic [`ADDR_W-1:0] addr;
		desc_t              d;
		int                 len;
		int                 off;
		pos = `POS_W'($urandom);
		if ($urandom_range(0, 2) == 0) begin
			pos = pos & `POS_W'($urandom);	// sparser token starts
		end
		for (int b = 0; b < `SLICE_BYTES + 2; b++) begin
			bytes[b] = 8'($urandom);
		end
		slice_addr_i = next_addr;
		addr = next_addr;
		// replace unsupported tags before decoding since a tag may be an earlier copy's offset byte
		for (int b = 0; b < `SLICE_BYTES; b++) begin
			if (pos[`POS_W - 1 - b] && bytes[b][1:0] == 2'b11) begin
				bytes[b][1:0] = 2'($urandom_range(0, 2));
			end
		end
		for (int b = 0; b < `SLICE_BYTES; b++) begin
			if (pos[`POS_W - 1 - b]) begin
				case (bytes[b][1:0])
					2'b00: begin
						d.kind = tok_literal;
						len = bytes[b][7:2] + 1;
						off = 0;
					end
					2'b01: begin
						d.kind = tok_copy;
						len = bytes[b][4:2] + 4;
						off = bytes[b][7:5] * 256 + bytes[b + 1];
					end
					default: begin	// offset bytes may be lookahead bytes
						d.kind = tok_copy;
						len = bytes[b][7:2] + 1;
						off = bytes[b + 2] * 256 + bytes[b + 1];
					end
				endcase
				d.addr = addr;
				d.len = `LEN_W'(len);
				d.off = `OFF_W'(off);
				exp_q[(addr >> `LANE_SEL_LSB) % `NUM_LANES].push_back(d);
				addr = addr + `ADDR_W'(len);
			end
		end
		for (int b = 0; b < `SLICE_BYTES + 2; b++) begin
			slice_data_i[`DATA_W - 1 - 8 * b -: 8] = bytes[b];
		end
		next_addr = addr;
		slice_pos_i = pos;
		slice_valid_i = 1'b1;
		@(negedge clk);
		slice_valid_i = 1'b0;
	endtask

	task automatic wait_ready(input int limit);
		int waited;
		waited = 0;
		while (!ready_o) begin
			@(negedge clk);
			waited++;
			if (waited > limit) begin
				report_timeout("ready_o");
			end
		end
	endtask

	task automatic wait_idle(input int limit);
		int waited;
		waited = 0;
		while (!all_empty_o) begin
			@(negedge clk);
			waited++;
			if (waited > limit) begin
				report_timeout("all_empty_o");
			end
		end
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (pending_count() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("every expected descriptor to reach its lane");
			end
		end
	endtask

	// stop all reads and keep offering slices until the stall holds ready_o low
	task automatic fill_lanes();
		int low_run;
		int waited;
		low_run = 0;
		waited = 0;
		@(posedge clk);
		read_en = 1'b0;
		@(negedge clk);
		while (low_run < 50) begin
			if (ready_o) begin
				drive_slice();
				low_run = 0;
			end else begin
				@(negedge clk);
				low_run++;
			end
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("ready_o to stay low with all reads stopped");
			end
		end
		@(posedge clk);
		read_en = 1'b1;
		@(negedge clk);
	endtask

	// consumer, reads each valid lane head with a random rate
	initial begin
		desc_t got;
		lane_rd_i = '0;
		forever begin
			@(negedge clk);
			for (int l = 0; l < `NUM_LANES; l++) begin
				lane_rd_i[l] = 1'b0;
				if (read_en && lane_valid_o[l] && $urandom_range(0, 3) != 0) begin
					got.kind = lane_kind_o[l];
					got.addr = lane_addr_o[l];
					got.len = lane_len_o[l];
					got.off = lane_off_o[l];
					take_head(l, got);
					lane_rd_i[l] = 1'b1;
				end
			end
		end
	end

	initial begin
		void'($urandom(52));
		rst_n = 1'b0;
		slice_valid_i = 1'b0;
		slice_data_i = '0;
		slice_pos_i = '0;
		slice_addr_i = '0;
		next_addr = `ADDR_W'($urandom);
		delivered = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value(`ADDR_W'(lane_valid_o), '0, "lane_valid_o after reset");
		check_flag(all_empty_o, 1'b0, "all_empty_o after reset");
		wait_ready(2);
		wait_idle(3);
		check_value(`ADDR_W'(lane_valid_o), '0, "lane_valid_o before the first slice");

		@(posedge clk);
		read_en = 1'b1;
		@(negedge clk);
		repeat (60) begin
			wait_ready(WAIT_LIMIT);
			drive_slice();
		end

		fill_lanes();	// back-pressure, then reads resume
		repeat (40) begin
			wait_ready(WAIT_LIMIT);
			drive_slice();
		end

		wait_drained();
		wait_idle(WAIT_LIMIT);
		repeat (4) @(negedge clk);
		check_value(`ADDR_W'(lane_valid_o), '0, "lane_valid_o when idle");
		check_flag(all_empty_o, 1'b1, "all_empty_o when idle");
		$display("%0d descriptors delivered", delivered);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* verilog/leading_zero_count.sv */
// 16-bit leading-zero counter for the token-start bitmap.
// Bit 15 is the first byte; count_o is only meaningful while any_o is high.

`timescale 1ns/1ps

module leading_zero_count (
	input  logic [15:0] bits_i,
	output logic        any_o,
	output logic [3:0]  count_o
);

	logic [3:0] nib_any;		// index 0 is the top nibble
	logic [1:0] nib_zeros [4];
	logic [1:0] grp_zeros;

	// four-bit priority encoder, result is {any, leading zeros}
	function automatic logic [2:0] penc4(input logic [3:0] x);
		logic [1:0] z;
		z[1] = ~(x[3] | x[2]);
		z[0] = ~(x[3] | (~x[2] & x[1]));
		return {|x, z};
	endfunction

	always_comb begin
		for (int g = 0; g < 4; g++) begin
			{nib_any[g], nib_zeros[g]} = penc4(bits_i[15 - 4 * g -: 4]);
		end

		// second level picks the first nibble holding a set bit
		{any_o, grp_zeros} = penc4({nib_any[0], nib_any[1], nib_any[2], nib_any[3]});
		count_o = {grp_zeros, nib_zeros[grp_zeros]};
	end

endmodule

/* verilog/parser_status.sv */
// Collects the lane flags into the tokenizer stall and the idle report.
// Both outputs are registered, so the stall trails the flags by one cycle.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module parser_status (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`NUM_LANES-1:0] lane_almost_full_i,
	input  logic [`NUM_LANES-1:0] lane_empty_i,
	input  logic                  slice_ready_i,
	output logic                  stall_o,
	output logic                  all_empty_o
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stall_o     <= 1'b0;
			all_empty_o <= 1'b0;
		end else begin
			stall_o     <= |lane_almost_full_i;	// any lane near full
			// idle means no slice held and nothing queued in any lane
			all_empty_o <= (&lane_empty_i) && slice_ready_i;
		end
	end

endmodule

/* verilog/slice_tokenizer.sv */
// Splits one slice into token descriptors, one per unstalled cycle.
// The slice is shifted so that the current token tag always sits at byte 0;
// the leading-zero count on the start bitmap gives the distance to the next.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module slice_tokenizer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           slice_valid_i,
	input  logic [`DATA_W-1:0]             slice_data_i,
	input  logic [`POS_W-1:0]              slice_pos_i,
	input  logic [`ADDR_W-1:0]             slice_addr_i,
	input  logic                           stall_i,
	output logic                           ready_o,
	output logic                           tok_valid_o,
	output snappy_parser_pkg::token_kind_e tok_kind_o,
	output logic [`ADDR_W-1:0]             tok_addr_o,
	output logic [`LEN_W-1:0]              tok_len_o,
	output logic [`OFF_W-1:0]              tok_off_o
);

	import snappy_parser_pkg::*;

	localparam int SHIFT_W = $clog2(`SLICE_BYTES) + 3;

	parser_state_e state_q;

	logic [`DATA_W-1:0] data_q;		// byte 0 in the top bits
	logic [`POS_W-1:0]  pos_q;
	logic [`ADDR_W-1:0] addr_q;		// output address of the token at byte 0

	logic [7:0] tag;
	logic [7:0] byte1;
	logic [7:0] byte2;

	token_kind_e       kind_d;
	logic [`LEN_W-1:0] len_d;
	logic [`OFF_W-1:0] off_d;

	logic [`POS_W-1:0]  lzc_bits;
	logic               lzc_any;
	logic [3:0]         lzc_count;
	logic [SHIFT_W-1:0] shift_bits;

	assign ready_o = (state_q == st_load);

	// in st_split byte 0 is the current token, so look past it
	assign lzc_bits = (state_q == st_split) ? {1'b0, pos_q[`POS_W-2:0]} : pos_q;

	leading_zero_count u_lzc (
		.bits_i  (lzc_bits),
		.any_o   (lzc_any),
		.count_o (lzc_count)
	);

	assign shift_bits = {lzc_count, 3'b000};

	assign tag   = data_q[`DATA_W-1 -: 8];
	assign byte1 = data_q[`DATA_W-9 -: 8];
	assign byte2 = data_q[`DATA_W-17 -: 8];	// may come from the lookahead bytes

	// tag decode
	always_comb begin
		case (tag[1:0])
			2'b00: begin
				kind_d = tok_literal;
				len_d  = `LEN_W'(tag[7:2]) + `LEN_W'(1);
				off_d  = '0;
			end
			2'b01: begin	// 2-byte copy, 11-bit offset
				kind_d = tok_copy;
				len_d  = `LEN_W'(tag[4:2]) + `LEN_W'(4);
				off_d  = `OFF_W'({tag[7:5], byte1});
			end
			default: begin	// 3-byte copy, offset low byte first
				kind_d = tok_copy;
				len_d  = `LEN_W'(tag[7:2]) + `LEN_W'(1);
				off_d  = {byte2, byte1};
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= st_idle;
			tok_valid_o <= 1'b0;
		end else begin
			tok_valid_o <= 1'b0;
			case (state_q)
				st_idle: state_q <= st_load;
				st_load: begin
					if (slice_valid_i) begin
						state_q <= st_align;
					end
				end
				st_align: begin
					// a slice without any start bit is dropped here
					if (!stall_i) begin
						state_q <= lzc_any ? st_split : st_load;
					end
				end
				st_split: begin
					if (!stall_i) begin
						tok_valid_o <= 1'b1;
						if (!lzc_any) begin
							state_q <= st_load;	// last token of the slice
						end
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// slice buffers and descriptor fields
	always_ff @(posedge clk) begin
		case (state_q)
			st_load: begin
				if (slice_valid_i) begin
					data_q <= slice_data_i;
					pos_q  <= slice_pos_i;
					addr_q <= slice_addr_i;
				end
			end
			st_align: begin
				if (!stall_i) begin
					data_q <= data_q << shift_bits;
					pos_q  <= pos_q << lzc_count;
				end
			end
			st_split: begin
				if (!stall_i) begin
					tok_kind_o <= kind_d;
					tok_addr_o <= addr_q;
					tok_len_o  <= len_d;
					tok_off_o  <= off_d;
					data_q     <= data_q << shift_bits;
					pos_q      <= pos_q << lzc_count;
					addr_q     <= addr_q + `ADDR_W'(len_d);
				end
			end
			default: ;
		endcase
	end

endmodule

/* verilog/snappy_parser.sv */
// Second-level token splitter of a Snappy decompressor.
// Accepts one slice at a time while ready_o is high and hands token
// descriptors to NUM_LANES lane queues chosen by output address bank.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module snappy_parser (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            slice_valid_i,
	input  logic [`DATA_W-1:0]                              slice_data_i,
	input  logic [`POS_W-1:0]                               slice_pos_i,
	input  logic [`ADDR_W-1:0]                              slice_addr_i,
	output logic                                            ready_o,
	input  logic [`NUM_LANES-1:0]                           lane_rd_i,
	output logic [`NUM_LANES-1:0]                           lane_valid_o,
	output snappy_parser_pkg::token_kind_e [`NUM_LANES-1:0] lane_kind_o,
	output logic [`NUM_LANES-1:0][`ADDR_W-1:0]              lane_addr_o,
	output logic [`NUM_LANES-1:0][`LEN_W-1:0]               lane_len_o,
	output logic [`NUM_LANES-1:0][`OFF_W-1:0]               lane_off_o,
	output logic                                            all_empty_o
);

	import snappy_parser_pkg::*;

	// descriptor broadcast to every lane
	logic               tok_valid;
	token_kind_e        tok_kind;
	logic [`ADDR_W-1:0] tok_addr;
	logic [`LEN_W-1:0]  tok_len;
	logic [`OFF_W-1:0]  tok_off;

	logic [`NUM_LANES-1:0] lane_almost_full;
	logic [`NUM_LANES-1:0] lane_empty;
	logic                  stall;

	slice_tokenizer u_tokenizer (
		.clk           (clk),
		.rst_n         (rst_n),
		.slice_valid_i (slice_valid_i),
		.slice_data_i  (slice_data_i),
		.slice_pos_i   (slice_pos_i),
		.slice_addr_i  (slice_addr_i),
		.stall_i       (stall),
		.ready_o       (ready_o),
		.tok_valid_o   (tok_valid),
		.tok_kind_o    (tok_kind),
		.tok_addr_o    (tok_addr),
		.tok_len_o     (tok_len),
		.tok_off_o     (tok_off)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		token_lane #(
			.LANE_ID (i)
		) u_lane (
			.clk           (clk),
			.rst_n         (rst_n),
			.tok_valid_i   (tok_valid),
			.tok_kind_i    (tok_kind),
			.tok_addr_i    (tok_addr),
			.tok_len_i     (tok_len),
			.tok_off_i     (tok_off),
			.rd_i          (lane_rd_i[i]),
			.valid_o       (lane_valid_o[i]),
			.kind_o        (lane_kind_o[i]),
			.addr_o        (lane_addr_o[i]),
			.len_o         (lane_len_o[i]),
			.off_o         (lane_off_o[i]),
			.almost_full_o (lane_almost_full[i]),
			.empty_o       (lane_empty[i])
		);
	end

	parser_status u_status (
		.clk                (clk),
		.rst_n              (rst_n),
		.lane_almost_full_i (lane_almost_full),
		.lane_empty_i       (lane_empty),
		.slice_ready_i      (ready_o),		// tokenizer waits for a slice
		.stall_o            (stall),
		.all_empty_o        (all_empty_o)
	);

endmodule

/* verilog/snappy_parser_defs.svh */
// Widths, lane count and queue thresholds shared by the token splitter RTL
// and its testbench. Include wherever one of these macros is needed.

`ifndef SNAPPY_PARSER_DEFS_SVH
`define SNAPPY_PARSER_DEFS_SVH

// slice format
`define SLICE_BYTES 16
`define DATA_W 144
`define POS_W 16

// descriptor fields
`define ADDR_W 16
`define LEN_W 7
`define OFF_W 16

// lane queues, bank field sits at output address bits [LSB+1:LSB]
`define NUM_LANES 4
`define LANE_SEL_LSB 3
`define LANE_DEPTH 8

// almost-full level, leaves room for descriptors in flight behind the stall
`define LANE_PROG_FULL 6

`endif

/* verilog/snappy_parser_pkg.sv */
// Types of the Snappy second-level token splitter.
// Modules import this inside their body and use scoped names on ports.

package snappy_parser_pkg;

	// tokenizer FSM, tracks the slice currently held
	typedef enum logic [1:0] {
		st_idle,	// after reset, one cycle
		st_load,	// waiting for a slice, ready is high
		st_align,	// skip bytes before the first token start
		st_split	// one token per unstalled cycle
	} parser_state_e;

	// descriptor kind
	typedef enum logic {
		tok_literal,
		tok_copy
	} token_kind_e;

endpackage

/* verilog/token_lane.sv */
// One lane queue of token descriptors.
// Takes only descriptors whose address bank matches LANE_ID and shows the
// oldest one on its outputs with valid_o until the consumer pops it with rd_i.

`timescale 1ns/1ps

`include "snappy_parser_defs.svh"

module token_lane #(
	parameter int LANE_ID = 0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           tok_valid_i,
	input  snappy_parser_pkg::token_kind_e tok_kind_i,
	input  logic [`ADDR_W-1:0]             tok_addr_i,
	input  logic [`LEN_W-1:0]              tok_len_i,
	input  logic [`OFF_W-1:0]              tok_off_i,
	input  logic                           rd_i,
	output logic                           valid_o,
	output snappy_parser_pkg::token_kind_e kind_o,
	output logic [`ADDR_W-1:0]             addr_o,
	output logic [`LEN_W-1:0]              len_o,
	output logic [`OFF_W-1:0]              off_o,
	output logic                           almost_full_o,
	output logic                           empty_o
);

	import snappy_parser_pkg::*;

	localparam int PTR_W = $clog2(`LANE_DEPTH);
	localparam int SEL_W = $clog2(`NUM_LANES);

	token_kind_e        kind_mem [`LANE_DEPTH];
	logic [`ADDR_W-1:0] addr_mem [`LANE_DEPTH];
	logic [`LEN_W-1:0]  len_mem  [`LANE_DEPTH];
	logic [`OFF_W-1:0]  off_mem  [`LANE_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q;		// entries in the queue, head register excluded
	logic             wr_en;
	logic             pop;

	assign wr_en = tok_valid_i && (tok_addr_i[`LANE_SEL_LSB +: SEL_W] == SEL_W'(LANE_ID));

	// refill the head when it is empty or being read
	assign pop = (count_q != '0) && (!valid_o || rd_i);

	assign almost_full_o = (count_q >= (PTR_W + 1)'(`LANE_PROG_FULL));
	assign empty_o       = (count_q == '0) && !valid_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			valid_o  <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({wr_en, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
			if (pop) begin
				valid_o <= 1'b1;
			end else if (rd_i) begin
				valid_o <= 1'b0;	// head read with nothing behind it
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			kind_mem[wr_ptr_q] <= tok_kind_i;
			addr_mem[wr_ptr_q] <= tok_addr_i;
			len_mem[wr_ptr_q]  <= tok_len_i;
			off_mem[wr_ptr_q]  <= tok_off_i;
		end
		if (pop) begin
			kind_o <= kind_mem[rd_ptr_q];
			addr_o <= addr_mem[rd_ptr_q];
			len_o  <= len_mem[rd_ptr_q];
			off_o  <= off_mem[rd_ptr_q];
		end
	end

endmodule
